//--- verilog/recog_pkg.sv
`default_nettype none

package recog_pkg;

    localparam int CANVAS_W      = 32;
    localparam int CANVAS_PIXELS = 1024;
    localparam int POOL_K        = 4;      // pooling block side
    localparam int FEAT_W        = 8;      // pooled side
    localparam int NUM_FEATS     = 64;
    localparam int NUM_CLASSES   = 10;
    localparam int WB_BIAS_BASE  = 640;    // biases follow the weight block
    localparam int WB_WORDS      = WB_BIAS_BASE + NUM_CLASSES;

    typedef logic [9:0]          canvas_addr_t;  // y in [9:5], x in [4:0]
    typedef logic [5:0]          feat_idx_t;
    typedef logic [3:0]          class_t;
    typedef logic signed [15:0]  weight_t;
    typedef logic signed [23:0]  score_t;
    typedef logic [9:0]          wb_adr_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_READ,
        PH_DENSE,
        PH_DONE
    } phase_e;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        wb_adr_t     adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic      clear;       // load bias
        logic      accumulate;
        logic      last;        // final feature of the class
        class_t    cls;
        feat_idx_t feat;
    } mac_ctrl_t;

    typedef struct packed {
        logic   valid;
        class_t cls;
        score_t score;
    } class_score_t;

endpackage

`default_nettype wire

//--- verilog/layer_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    output recog_pkg::canvas_addr_t read_addr_o,
    output logic                    read_enable_o,
    output logic                    pending_o,
    output logic                    done_o,
    output logic                    feat_clear_o,
    output recog_pkg::wb_adr_t      rd_adr_o,
    output recog_pkg::mac_ctrl_t    mac_ctrl_o
);
    import recog_pkg::*;

    phase_e       phase;
    canvas_addr_t pix_cnt;
    class_t       cls_cnt;
    logic [6:0]   step;      // 0 bias, 1..64 features, 65 drain
    feat_idx_t    feat;
    logic         dense;
    mac_ctrl_t    ctrl_d;

    assign dense         = (phase == PH_DENSE);
    assign feat          = feat_idx_t'(step - 7'd1);
    assign read_addr_o   = pix_cnt;
    assign read_enable_o = (phase == PH_READ);
    assign pending_o     = (phase == PH_READ) || dense;
    assign done_o        = (phase == PH_DONE) && (step == '0);
    assign feat_clear_o  = (phase == PH_IDLE) && start_i;
    assign rd_adr_o      = (step == '0 || step > NUM_FEATS) ?
                           wb_adr_t'(WB_BIAS_BASE + cls_cnt) : {cls_cnt, feat};

    always_comb begin
        ctrl_d.clear      = dense && (step == '0);
        ctrl_d.accumulate = dense && (step != '0) && (step <= NUM_FEATS);
        ctrl_d.last       = dense && (step == NUM_FEATS);
        ctrl_d.cls        = cls_cnt;
        ctrl_d.feat       = feat;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= PH_IDLE;
            pix_cnt    <= '0;
            cls_cnt    <= '0;
            step       <= '0;
            mac_ctrl_o <= '0;
        end else begin
            mac_ctrl_o <= ctrl_d;  // one behind the address, matches store latency
            case (phase)
                PH_IDLE: begin
                    pix_cnt <= '0;
                    cls_cnt <= '0;
                    step    <= '0;
                    if (start_i) phase <= PH_READ;
                end
                PH_READ: begin
                    pix_cnt <= pix_cnt + 1'b1;
                    if (pix_cnt == canvas_addr_t'(CANVAS_PIXELS - 1)) phase <= PH_DENSE;
                end
                PH_DENSE: begin
                    if (step == NUM_FEATS + 1) begin  // drain cycle
                        step    <= '0;
                        cls_cnt <= cls_cnt + 1'b1;
                        if (cls_cnt == class_t'(NUM_CLASSES - 1)) phase <= PH_DONE;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                PH_DONE: begin
                    // second cycle carries the result pulse
                    step <= step + 1'b1;
                    if (step != '0) phase <= PH_IDLE;
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // canvas reads never overlap MAC activity
    a_read_without_mac: assert property (@(posedge clk) disable iff (rst)
        read_enable_o |-> !(mac_ctrl_o.clear || mac_ctrl_o.accumulate || mac_ctrl_o.last));

endmodule

`default_nettype wire

//--- verilog/feature_map.sv
`timescale 1ns/1ps
`default_nettype none

module feature_map (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear_i,
    input  logic                    sample_i,
    input  recog_pkg::canvas_addr_t addr_i,
    input  logic                    pixel_i,
    input  recog_pkg::feat_idx_t    feat_idx_i,
    output logic                    feat_bit_o
);
    import recog_pkg::*;

    logic [NUM_FEATS-1:0] feats;
    feat_idx_t            pool_idx;

    // block row times pooled width plus block column
    assign pool_idx = feat_idx_t'((addr_i / CANVAS_W / POOL_K) * FEAT_W
                                  + (addr_i % CANVAS_W) / POOL_K);

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            feats <= '0;
        end else if (sample_i && pixel_i) begin
            feats[pool_idx] <= 1'b1;  // max of binary pixels
        end
    end

    always_ff @(posedge clk) begin
        feat_bit_o <= feats[feat_idx_i];  // aligned with weight read
    end

endmodule

`default_nettype wire

//--- verilog/weight_store.sv
`timescale 1ns/1ps
`default_nettype none

module weight_store (
    input  logic               clk,
    input  logic               rst,
    input  recog_pkg::wb_req_t wb_req_i,
    output recog_pkg::wb_rsp_t wb_rsp_o,
    input  logic               busy_i,
    input  recog_pkg::wb_adr_t rd_adr_i,
    output recog_pkg::weight_t rd_data_o
);
    import recog_pkg::*;

    weight_t     mem [WB_WORDS];
    logic        req;
    logic        in_map;
    logic        accept;
    logic        ack_q;
    logic [15:0] rdat_q;

    assign req    = wb_req_i.cyc && wb_req_i.stb;
    assign in_map = wb_req_i.adr < wb_adr_t'(WB_WORDS);
    assign accept = req && !ack_q && !busy_i;  // held off during a run

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && wb_req_i.we && in_map) begin
            mem[wb_req_i.adr] <= wb_req_i.dat;
        end
        rdat_q <= in_map ? mem[wb_req_i.adr] : '0;
    end

    // MAC read port
    always_ff @(posedge clk) begin
        rd_data_o <= (rd_adr_i < wb_adr_t'(WB_WORDS)) ? mem[rd_adr_i] : '0;
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdat_q;

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_rsp_o.ack) |-> $past(req) && req);

endmodule

`default_nettype wire

//--- verilog/dense_mac.sv
`timescale 1ns/1ps
`default_nettype none

module dense_mac (
    input  logic                    clk,
    input  logic                    rst,
    input  recog_pkg::mac_ctrl_t    ctrl_i,
    input  recog_pkg::weight_t      weight_i,
    input  logic                    feat_bit_i,
    output recog_pkg::class_score_t score_o
);
    import recog_pkg::*;

    score_t acc;
    score_t addend;
    score_t sum;

    assign addend = feat_bit_i ? score_t'(weight_i) : '0;
    assign sum    = acc + addend;

    always_ff @(posedge clk) begin
        if (ctrl_i.clear) begin
            acc <= score_t'(weight_i);  // bias is the start value
        end else if (ctrl_i.accumulate) begin
            acc <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            score_o.valid <= 1'b0;
        end else begin
            score_o.valid <= ctrl_i.last;
        end
        score_o.cls   <= ctrl_i.cls;
        score_o.score <= sum;  // includes the final weight
    end

    // last step is the final feature of the class
    a_last_on_final_feat: assert property (@(posedge clk) disable iff (rst)
        ctrl_i.last |-> ctrl_i.accumulate && (ctrl_i.feat == feat_idx_t'(NUM_FEATS - 1)));

endmodule

`default_nettype wire

//--- verilog/argmax_result.sv
`timescale 1ns/1ps
`default_nettype none

module argmax_result (
    input  logic                    clk,
    input  logic                    rst,
    input  recog_pkg::class_score_t score_i,
    input  logic                    done_i,
    output logic                    result_valid_o,
    output recog_pkg::class_t       result_o
);
    import recog_pkg::*;

    score_t best_score;
    class_t best_cls;
    logic   take;
    class_t win_cls;

    // strictly greater, so the earliest class keeps a tie
    assign take    = score_i.valid && (score_i.cls == '0 || score_i.score > best_score);
    assign win_cls = take ? score_i.cls : best_cls;  // last class may still be in flight

    always_ff @(posedge clk) begin
        if (rst) begin
            best_cls       <= '0;
            result_valid_o <= 1'b0;
            result_o       <= '0;
        end else begin
            if (take) best_cls <= score_i.cls;
            result_valid_o <= done_i;
            if (done_i) result_o <= win_cls;
        end
        if (take) best_score <= score_i.score;
    end

    a_class_in_range: assert property (@(posedge clk) disable iff (rst)
        score_i.valid |-> score_i.cls < class_t'(NUM_CLASSES));

endmodule

`default_nettype wire

//--- verilog/recognizer.sv
`timescale 1ns/1ps
`default_nettype none

module recognizer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  logic                    read_data_i,
    output recog_pkg::canvas_addr_t read_addr_o,
    output logic                    read_enable_o,
    output logic                    pending_o,
    output logic                    result_valid_o,
    output recog_pkg::class_t       result_o,
    input  recog_pkg::wb_req_t      wb_req_i,
    output recog_pkg::wb_rsp_t      wb_rsp_o
);
    import recog_pkg::*;

    logic         done;
    logic         feat_clear;
    logic         feat_bit;
    wb_adr_t      rd_adr;
    weight_t      rd_weight;
    mac_ctrl_t    mac_ctrl;
    class_score_t class_score;

    layer_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_i),
        .read_addr_o   (read_addr_o),
        .read_enable_o (read_enable_o),
        .pending_o     (pending_o),
        .done_o        (done),
        .feat_clear_o  (feat_clear),
        .rd_adr_o      (rd_adr),
        .mac_ctrl_o    (mac_ctrl)
    );

    feature_map u_feat (
        .clk        (clk),
        .rst        (rst),
        .clear_i    (feat_clear),
        .sample_i   (read_enable_o),
        .addr_i     (read_addr_o),
        .pixel_i    (read_data_i),
        .feat_idx_i (rd_adr[5:0]),  // low bits of a weight address pick the feature
        .feat_bit_o (feat_bit)
    );

    weight_store u_store (
        .clk       (clk),
        .rst       (rst),
        .wb_req_i  (wb_req_i),
        .wb_rsp_o  (wb_rsp_o),
        .busy_i    (pending_o),
        .rd_adr_i  (rd_adr),
        .rd_data_o (rd_weight)
    );

    dense_mac u_mac (
        .clk        (clk),
        .rst        (rst),
        .ctrl_i     (mac_ctrl),
        .weight_i   (rd_weight),
        .feat_bit_i (feat_bit),
        .score_o    (class_score)
    );

    argmax_result u_argmax (
        .clk            (clk),
        .rst            (rst),
        .score_i        (class_score),
        .done_i         (done),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

//--- tests/recog_model.svh
`ifndef RECOG_MODEL_SVH
`define RECOG_MODEL_SVH

// 4x4 OR pooling, bit (y/4)*8 + x/4
function automatic logic [NUM_FEATS-1:0] pooled_features();
    logic [NUM_FEATS-1:0] f;
    f = '0;
    for (int y = 0; y < CANVAS_W; y++) begin
        for (int x = 0; x < CANVAS_W; x++) begin
            if (canvas[y][x]) f[(y / POOL_K) * FEAT_W + x / POOL_K] = 1'b1;
        end
    end
    return f;
endfunction

function automatic score_t class_score(int c, logic [NUM_FEATS-1:0] f);
    score_t s;
    s = score_t'(params[WB_BIAS_BASE + c]);
    for (int i = 0; i < NUM_FEATS; i++) begin
        if (f[i]) s = s + score_t'(params[c * NUM_FEATS + i]);
    end
    return s;
endfunction

function automatic class_t expected_class();
    logic [NUM_FEATS-1:0] f;
    score_t               best;
    class_t               win;
    f    = pooled_features();
    best = class_score(0, f);
    win  = '0;
    for (int c = 1; c < NUM_CLASSES; c++) begin
        if (class_score(c, f) > best) begin  // ties stay with the earlier class
            best = class_score(c, f);
            win  = class_t'(c);
        end
    end
    return win;
endfunction

task automatic expect_class(string name, class_t got, class_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic compare_word(string name, weight_t got, weight_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic verify_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic match_addr(string name, canvas_addr_t got, canvas_addr_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

`endif

//--- tests/recognizer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module recognizer_tb;
    import recog_pkg::*;

    localparam int DRIVE_DLY = 1;
    localparam int RUN_LIMIT = 4000;  // cycles, well over one run
    localparam int ACK_LIMIT = 4000;

    logic         clk;
    logic         rst;
    logic         start;
    logic         read_data;
    canvas_addr_t read_addr;
    logic         read_enable;
    logic         pending;
    logic         result_valid;
    class_t       result;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;

    logic [CANVAS_W-1:0] canvas [CANVAS_W];  // canvas[y][x]
    weight_t             params [WB_WORDS];  // mirror of the weight store
    int                  checks;
    int                  errors;
    int                  tests;
    int                  test_errors;
    string               test_name;

    `include "recog_model.svh"

    recognizer DUT (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start),
        .read_data_i    (read_data),
        .read_addr_o    (read_addr),
        .read_enable_o  (read_enable),
        .pending_o      (pending),
        .result_valid_o (result_valid),
        .result_o       (result),
        .wb_req_i       (wb_req),
        .wb_rsp_o       (wb_rsp)
    );

    assign read_data = canvas[read_addr[9:5]][read_addr[4:0]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic abort_run(string why);
        $display("timeout: %s", why);
        $display("sim failed");
        $finish;
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic close_test();
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic bus_access(input logic we, input wb_adr_t adr, input logic [15:0] wdat,
                              output logic [15:0] rdat);
        int n;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        n = 0;
        do begin
            next_cycle();
            n++;
            if (n > ACK_LIMIT) abort_run("Wishbone access got no ack");
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        next_cycle();  // stb stays up through the ack cycle
        wb_req = '0;
        next_cycle();  // one idle cycle between accesses
    endtask

    task automatic fill_canvas(int density);
        for (int y = 0; y < CANVAS_W; y++) begin
            for (int x = 0; x < CANVAS_W; x++) begin
                canvas[y][x] = ($urandom % 100) < density;
            end
        end
    endtask

    task automatic launch_run();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        verify_flag("pending_o", pending, 1'b1);
    endtask

    task automatic await_result(string what, class_t exp);
        int n;
        int reads;
        n     = 0;
        reads = 0;
        while (!result_valid) begin
            if (read_enable) begin
                match_addr("read_addr_o", read_addr, canvas_addr_t'(reads));
                reads++;
            end
            next_cycle();
            n++;
            if (n > RUN_LIMIT) abort_run({"no result pulse for ", what});
        end
        expect_class("result_o", result, exp);
        checks++;
        if (reads != CANVAS_PIXELS) begin
            errors++;
            $display("expected %0d canvas reads for %s, saw %0d", CANVAS_PIXELS, what, reads);
        end
        next_cycle();  // done phase ends after the pulse
    endtask

    task automatic run_canvas(string what);
        class_t exp;
        exp = expected_class();
        launch_run();
        await_result(what, exp);
    endtask

    initial begin
        logic [15:0] rdat;
        wb_adr_t     adr;
        class_t      exp;
        int          n;
        int          pulses;
        int          r;
        logic        early_ack;
        void'($urandom(32'hb86db491));
        checks = 0;
        errors = 0;
        tests  = 0;
        rst    = 1'b1;
        start  = 1'b0;
        wb_req = '0;
        fill_canvas(0);
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        begin_test("reset");
        verify_flag("pending_o", pending, 1'b0);
        verify_flag("read_enable_o", read_enable, 1'b0);
        verify_flag("result_valid_o", result_valid, 1'b0);
        verify_flag("wb ack", wb_rsp.ack, 1'b0);
        expect_class("result_o", result, '0);
        close_test();

        begin_test("parameter loading");
        for (int a = 0; a < WB_WORDS; a++) begin
            r = (a < WB_BIAS_BASE) ? int'($urandom % 128) - 64 : int'($urandom % 512) - 256;
            params[a] = weight_t'(r);
            bus_access(1'b1, wb_adr_t'(a), params[a], rdat);
        end
        for (int i = 0; i < 40; i++) begin
            adr = wb_adr_t'($urandom % WB_WORDS);
            bus_access(1'b0, adr, '0, rdat);
            compare_word("wb dat", weight_t'(rdat), params[adr]);
        end
        bus_access(1'b1, 10'd660, 16'h1234, rdat);  // outside the map
        bus_access(1'b0, 10'd660, '0, rdat);
        compare_word("wb dat", weight_t'(rdat), '0);
        bus_access(1'b0, 10'd1023, '0, rdat);
        compare_word("wb dat", weight_t'(rdat), '0);
        close_test();

        begin_test("random canvases");
        for (int d = 4; d <= 100; d += 16) begin
            fill_canvas(d);
            run_canvas("random canvas");
        end
        close_test();

        begin_test("edge canvases");
        fill_canvas(0);
        run_canvas("all-zero canvas");
        for (int i = 0; i < 4; i++) begin
            fill_canvas(0);
            canvas[$urandom % CANVAS_W][$urandom % CANVAS_W] = 1'b1;
            run_canvas("single-pixel canvas");
        end
        close_test();

        begin_test("back-pressure");
        fill_canvas(20);
        exp = expected_class();
        launch_run();
        adr    = wb_adr_t'(WB_BIAS_BASE + 7);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: 16'h7fff};
        early_ack = 1'b0;
        n = 0;
        while (!result_valid) begin
            next_cycle();
            if (pending && wb_rsp.ack) early_ack = 1'b1;
            n++;
            if (n > RUN_LIMIT) abort_run("no result pulse while a write was held");
        end
        expect_class("result_o", result, exp);  // run still used the old bias
        verify_flag("wb ack while pending", early_ack, 1'b0);
        n = 0;
        while (!wb_rsp.ack) begin
            next_cycle();
            n++;
            if (n > ACK_LIMIT) abort_run("held write was never acked");
        end
        next_cycle();  // stb stays up through the ack cycle
        wb_req      = '0;
        params[adr] = 16'h7fff;
        next_cycle();
        run_canvas("canvas after held write");
        close_test();

        begin_test("start while busy");
        fill_canvas(40);
        exp = expected_class();
        launch_run();
        pulses = 0;
        n = 0;
        repeat (RUN_LIMIT) begin
            start = (n == 100 || n == 1500);  // one pulse in each busy phase
            next_cycle();
            n++;
            if (result_valid) begin
                pulses++;
                expect_class("result_o", result, exp);
            end
        end
        checks++;
        if (pulses != 1) begin
            errors++;
            $display("expected one result pulse after start while busy, saw %0d", pulses);
        end
        verify_flag("pending_o", pending, 1'b0);
        close_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tests
verilog/recog_pkg.sv
verilog/layer_sequencer.sv
verilog/feature_map.sv
verilog/weight_store.sv
verilog/dense_mac.sv
verilog/argmax_result.sv
verilog/recognizer.sv
tests/recognizer_tb.sv

//--- Bender.yml
package:
  name: recognizer

sources:
  - files:
      - verilog/recog_pkg.sv
      - verilog/layer_sequencer.sv
      - verilog/feature_map.sv
      - verilog/weight_store.sv
      - verilog/dense_mac.sv
      - verilog/argmax_result.sv
      - verilog/recognizer.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/recognizer_tb.sv
